/* common/mm_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants of the matrix-multiply tile
// Tile and element sizes, FIFO and credit sizing
// Peripheral register offsets
// Scheduler state encoding and the stream word union
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mm_pkg;

  // Tile geometry in rows and columns
  localparam int unsigned MM_WIDTH  = 4;
  localparam int unsigned MM_HEIGHT = 4;

  localparam int unsigned ELEM_W = 16;
  localparam int unsigned DATA_W = MM_HEIGHT * ELEM_W;
  localparam int unsigned ACC_W  = 32;
  localparam int unsigned K_W    = 8;

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned Z_CREDITS  = 2;

  // Peripheral register map
  localparam logic [7:0] REG_K_OFFS       = 8'h40;
  localparam logic [7:0] REG_TRIGGER_OFFS = 8'h54;
  localparam logic [7:0] REG_STATUS_OFFS  = 8'h0C;

  // Derived widths and sized limits
  localparam int unsigned ROW_W      = $clog2(MM_WIDTH);
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned CRED_W     = $clog2(Z_CREDITS + 1);

  localparam logic [ROW_W-1:0]      LAST_ROW   = ROW_W'(MM_WIDTH - 1);
  localparam logic [FIFO_PTR_W-1:0] FIFO_LAST  = FIFO_PTR_W'(FIFO_DEPTH - 1);
  localparam logic [FIFO_CNT_W-1:0] FIFO_FULL  = FIFO_CNT_W'(FIFO_DEPTH);
  localparam logic [CRED_W-1:0]     CRED_INIT  = CRED_W'(Z_CREDITS);

  typedef enum logic [2:0] {
    IDLE,
    BIAS,
    MAC,
    DRAIN,
    DONE
  } mm_state_e;

  // One stream word as raw bits for transport or split into lanes
  // Lane i holds element i of a row (or of an X column)
  typedef union packed {
    logic        [DATA_W-1:0]                raw;
    logic signed [MM_HEIGHT-1:0][ELEM_W-1:0] lane;
  } mm_word_u;

endpackage

/* ctrl/mm_regfile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral register port of the tile
// K register, trigger decode, status readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mm_regfile (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   periph_req_i,
  input  logic [7:0]             periph_add_i,
  input  logic                   periph_wen_i,
  input  logic [31:0]            periph_wdata_i,
  output logic                   periph_gnt_o,
  output logic [31:0]            periph_rdata_o,
  output logic                   periph_r_valid_o,
  input  logic                   busy_i,
  output logic [mm_pkg::K_W-1:0] k_size_o,
  output logic                   start_o
);

  logic                   wr_acc;
  logic                   rd_acc;
  logic [mm_pkg::K_W-1:0] k_q;
  logic [31:0]            rd_mux;

  // Reads always pass, writes only while no job runs
  assign periph_gnt_o = periph_req_i & (periph_wen_i | ~busy_i);

  // wen is active low
  assign wr_acc = periph_gnt_o & ~periph_wen_i;
  assign rd_acc = periph_gnt_o & periph_wen_i;

  assign start_o  = wr_acc & (periph_add_i == mm_pkg::REG_TRIGGER_OFFS);
  assign k_size_o = k_q;

  always_comb begin
    rd_mux = '0;
    case (periph_add_i)
      mm_pkg::REG_K_OFFS:      rd_mux[mm_pkg::K_W-1:0] = k_q;
      mm_pkg::REG_STATUS_OFFS: rd_mux[0] = busy_i;
      default:                 rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      k_q              <= '0;
      periph_r_valid_o <= 1'b0;
    end else begin
      periph_r_valid_o <= rd_acc;
      if (wr_acc && (periph_add_i == mm_pkg::REG_K_OFFS)) begin
        k_q <= periph_wdata_i[mm_pkg::K_W-1:0];
      end
    end
  end

  // Read data follows the granted read by one cycle
  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      periph_rdata_o <= rd_mux;
    end
  end

endmodule

/* logic/mm_stream_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Valid/ready input FIFO for one operand stream
// Circular buffer, head exposed to the consumer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mm_stream_fifo (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_valid_i,
  input  mm_pkg::mm_word_u push_data_i,
  output logic             push_ready_o,
  input  logic             pop_i,
  output logic             head_valid_o,
  output mm_pkg::mm_word_u head_data_o
);

  mm_pkg::mm_word_u              mem_q [mm_pkg::FIFO_DEPTH];
  logic [mm_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
  logic [mm_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
  logic [mm_pkg::FIFO_CNT_W-1:0] count_q;
  logic                          do_push;
  logic                          do_pop;

  assign push_ready_o = (count_q != mm_pkg::FIFO_FULL);
  assign head_valid_o = (count_q != '0);
  assign head_data_o  = mem_q[rd_ptr_q];

  assign do_push = push_valid_i & push_ready_o;
  // A pop on an empty FIFO is ignored
  assign do_pop  = pop_i & head_valid_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == mm_pkg::FIFO_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == mm_pkg::FIFO_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* engine/mm_engine.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Accumulator array of the tile
// Bias load, multiply-accumulate step, row readout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mm_engine (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     clear_i,
  input  logic                     bias_load_i,
  input  logic [mm_pkg::ROW_W-1:0] bias_row_i,
  input  logic                     mac_step_i,
  input  mm_pkg::mm_word_u         x_col_i,
  input  mm_pkg::mm_word_u         w_row_i,
  input  mm_pkg::mm_word_u         y_row_i,
  input  logic [mm_pkg::ROW_W-1:0] rd_row_i,
  output mm_pkg::mm_word_u         z_row_o
);

  logic [mm_pkg::MM_WIDTH-1:0][mm_pkg::MM_HEIGHT-1:0][mm_pkg::ACC_W-1:0] acc_q;
  logic [mm_pkg::MM_WIDTH-1:0][mm_pkg::MM_HEIGHT-1:0][mm_pkg::ACC_W-1:0] prod;

  function automatic logic [mm_pkg::ACC_W-1:0] sext(
    input logic [mm_pkg::ELEM_W-1:0] v
  );
    return {{(mm_pkg::ACC_W - mm_pkg::ELEM_W){v[mm_pkg::ELEM_W-1]}}, v};
  endfunction

  // Outer product of the current X column and W row
  // Low ACC_W bits of the extended product are exact in two's complement
  always_comb begin
    for (int r = 0; r < mm_pkg::MM_WIDTH; r++) begin
      for (int c = 0; c < mm_pkg::MM_HEIGHT; c++) begin
        prod[r][c] = sext(x_col_i.lane[r]) * sext(w_row_i.lane[c]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      acc_q <= '0;
    end else if (bias_load_i) begin
      // Y row seeds one accumulator row
      for (int c = 0; c < mm_pkg::MM_HEIGHT; c++) begin
        acc_q[bias_row_i][c] <= sext(y_row_i.lane[c]);
      end
    end else if (mac_step_i) begin
      for (int r = 0; r < mm_pkg::MM_WIDTH; r++) begin
        for (int c = 0; c < mm_pkg::MM_HEIGHT; c++) begin
          acc_q[r][c] <= acc_q[r][c] + prod[r][c];
        end
      end
    end
  end

  // Readout wraps each accumulator to element width
  always_comb begin
    for (int c = 0; c < mm_pkg::MM_HEIGHT; c++) begin
      z_row_o.lane[c] = acc_q[rd_row_i][c][mm_pkg::ELEM_W-1:0];
    end
  end

endmodule

/* logic/mm_scheduler.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Job sequencer FSM of the tile
// Bias load, K inner steps, row handover to drain,
// busy flag and end-of-job event
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mm_scheduler (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     start_i,
  input  logic [mm_pkg::K_W-1:0]   k_size_i,
  input  logic                     x_valid_i,
  input  logic                     w_valid_i,
  input  logic                     y_valid_i,
  input  logic                     drain_free_i,
  output logic                     busy_o,
  output logic                     evt_o,
  output logic                     clear_o,
  output logic                     x_pop_o,
  output logic                     w_pop_o,
  output logic                     y_pop_o,
  output logic                     bias_load_o,
  output logic                     mac_step_o,
  output logic [mm_pkg::ROW_W-1:0] row_idx_o,
  output logic                     drain_load_o
);

  mm_pkg::mm_state_e        state_q;
  logic [mm_pkg::ROW_W-1:0] row_q;
  logic [mm_pkg::K_W-1:0]   step_q;
  logic [mm_pkg::K_W-1:0]   k_last;
  logic                     row_last;

  // K of zero runs a single step
  assign k_last    = (k_size_i == '0) ? '0 : k_size_i - 1'b1;
  assign row_last  = (row_q == mm_pkg::LAST_ROW);
  assign row_idx_o = row_q;

  // Pops line up with the cycle a head is consumed
  always_comb begin
    clear_o      = 1'b0;
    y_pop_o      = 1'b0;
    bias_load_o  = 1'b0;
    x_pop_o      = 1'b0;
    w_pop_o      = 1'b0;
    mac_step_o   = 1'b0;
    drain_load_o = 1'b0;
    case (state_q)
      mm_pkg::IDLE: clear_o = start_i;
      mm_pkg::BIAS: begin
        y_pop_o     = y_valid_i;
        bias_load_o = y_valid_i;
      end
      mm_pkg::MAC: begin
        mac_step_o = x_valid_i & w_valid_i;
        x_pop_o    = x_valid_i & w_valid_i;
        w_pop_o    = x_valid_i & w_valid_i;
      end
      mm_pkg::DRAIN: drain_load_o = drain_free_i;
      default: clear_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= mm_pkg::IDLE;
      row_q   <= '0;
      step_q  <= '0;
      busy_o  <= 1'b0;
      evt_o   <= 1'b0;
    end else begin
      evt_o <= 1'b0;
      case (state_q)
        mm_pkg::IDLE: begin
          if (start_i) begin
            state_q <= mm_pkg::BIAS;
            busy_o  <= 1'b1;
            row_q   <= '0;
            step_q  <= '0;
          end
        end
        mm_pkg::BIAS: begin
          if (bias_load_o) begin
            row_q   <= row_last ? '0 : row_q + 1'b1;
            state_q <= row_last ? mm_pkg::MAC : mm_pkg::BIAS;
          end
        end
        mm_pkg::MAC: begin
          if (mac_step_o) begin
            step_q  <= (step_q == k_last) ? '0 : step_q + 1'b1;
            state_q <= (step_q == k_last) ? mm_pkg::DRAIN : mm_pkg::MAC;
          end
        end
        mm_pkg::DRAIN: begin
          if (drain_load_o) begin
            if (row_last) begin
              state_q <= mm_pkg::DONE;
            end else begin
              row_q <= row_q + 1'b1;
            end
          end
        end
        mm_pkg::DONE: begin
          // Last row has left the drain
          if (drain_free_i) begin
            state_q <= mm_pkg::IDLE;
            busy_o  <= 1'b0;
            evt_o   <= 1'b1;
          end
        end
        default: state_q <= mm_pkg::IDLE;
      endcase
    end
  end

endmodule

/* logic/mm_z_drain.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Z output stage
// One-row output register and consumer credit count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mm_z_drain (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      load_i,
  input  mm_pkg::mm_word_u          row_i,
  input  logic                      z_credit_i,
  output logic                      free_o,
  output logic                      z_valid_o,
  output logic [mm_pkg::DATA_W-1:0] z_data_o
);

  mm_pkg::mm_word_u          row_q;
  logic                      full_q;
  logic [mm_pkg::CRED_W-1:0] credit_q;
  logic                      send;

  // A held row goes out only while the consumer has room
  assign send      = full_q & (credit_q != '0);
  assign z_valid_o = send;
  assign z_data_o  = row_q.raw;

  // Register can take a new row in the cycle the old one leaves
  assign free_o = ~full_q | send;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q   <= 1'b0;
      credit_q <= mm_pkg::CRED_INIT;
    end else begin
      if (load_i) begin
        full_q <= 1'b1;
      end else if (send) begin
        full_q <= 1'b0;
      end
      // Returned credit and a send in one cycle cancel out
      case ({send, z_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      row_q <= row_i;
    end
  end

endmodule

/* logic/mm_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the matrix-multiply tile
// Register port, X/W/Y input FIFOs, scheduler,
// accumulator engine and Z drain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mm_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      periph_req_i,
  input  logic [7:0]                periph_add_i,
  input  logic                      periph_wen_i,
  input  logic [31:0]               periph_wdata_i,
  output logic                      periph_gnt_o,
  output logic [31:0]               periph_rdata_o,
  output logic                      periph_r_valid_o,
  input  logic                      x_valid_i,
  input  logic [mm_pkg::DATA_W-1:0] x_data_i,
  output logic                      x_ready_o,
  input  logic                      w_valid_i,
  input  logic [mm_pkg::DATA_W-1:0] w_data_i,
  output logic                      w_ready_o,
  input  logic                      y_valid_i,
  input  logic [mm_pkg::DATA_W-1:0] y_data_i,
  output logic                      y_ready_o,
  output logic                      z_valid_o,
  output logic [mm_pkg::DATA_W-1:0] z_data_o,
  input  logic                      z_credit_i,
  output logic                      busy_o,
  output logic                      evt_o
);

  logic [mm_pkg::K_W-1:0]   k_size;
  logic                     start;
  logic                     clear;
  logic                     x_pop, w_pop, y_pop;
  logic                     x_head_valid, w_head_valid, y_head_valid;
  mm_pkg::mm_word_u         x_head, w_head, y_head;
  logic                     bias_load;
  logic                     mac_step;
  logic [mm_pkg::ROW_W-1:0] row_idx;
  logic                     drain_load;
  logic                     drain_free;
  mm_pkg::mm_word_u         z_row;

  mm_regfile u_regfile (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .periph_req_i     ( periph_req_i     ),
    .periph_add_i     ( periph_add_i     ),
    .periph_wen_i     ( periph_wen_i     ),
    .periph_wdata_i   ( periph_wdata_i   ),
    .periph_gnt_o     ( periph_gnt_o     ),
    .periph_rdata_o   ( periph_rdata_o   ),
    .periph_r_valid_o ( periph_r_valid_o ),
    .busy_i           ( busy_o           ),
    .k_size_o         ( k_size           ),
    .start_o          ( start            )
  );

  // One X column per inner step
  mm_stream_fifo u_x_fifo (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .push_valid_i ( x_valid_i    ),
    .push_data_i  ( x_data_i     ),
    .push_ready_o ( x_ready_o    ),
    .pop_i        ( x_pop        ),
    .head_valid_o ( x_head_valid ),
    .head_data_o  ( x_head       )
  );

  // One W row per inner step
  mm_stream_fifo u_w_fifo (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .push_valid_i ( w_valid_i    ),
    .push_data_i  ( w_data_i     ),
    .push_ready_o ( w_ready_o    ),
    .pop_i        ( w_pop        ),
    .head_valid_o ( w_head_valid ),
    .head_data_o  ( w_head       )
  );

  // One bias row per output row
  mm_stream_fifo u_y_fifo (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .push_valid_i ( y_valid_i    ),
    .push_data_i  ( y_data_i     ),
    .push_ready_o ( y_ready_o    ),
    .pop_i        ( y_pop        ),
    .head_valid_o ( y_head_valid ),
    .head_data_o  ( y_head       )
  );

  mm_scheduler u_scheduler (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .start_i      ( start        ),
    .k_size_i     ( k_size       ),
    .x_valid_i    ( x_head_valid ),
    .w_valid_i    ( w_head_valid ),
    .y_valid_i    ( y_head_valid ),
    .drain_free_i ( drain_free   ),
    .busy_o       ( busy_o       ),
    .evt_o        ( evt_o        ),
    .clear_o      ( clear        ),
    .x_pop_o      ( x_pop        ),
    .w_pop_o      ( w_pop        ),
    .y_pop_o      ( y_pop        ),
    .bias_load_o  ( bias_load    ),
    .mac_step_o   ( mac_step     ),
    .row_idx_o    ( row_idx      ),
    .drain_load_o ( drain_load   )
  );

  mm_engine u_engine (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .clear_i     ( clear     ),
    .bias_load_i ( bias_load ),
    .bias_row_i  ( row_idx   ),
    .mac_step_i  ( mac_step  ),
    .x_col_i     ( x_head    ),
    .w_row_i     ( w_head    ),
    .y_row_i     ( y_head    ),
    .rd_row_i    ( row_idx   ),
    .z_row_o     ( z_row     )
  );

  mm_z_drain u_z_drain (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .load_i     ( drain_load ),
    .row_i      ( z_row      ),
    .z_credit_i ( z_credit_i ),
    .free_o     ( drain_free ),
    .z_valid_o  ( z_valid_o  ),
    .z_data_o   ( z_data_o   )
  );

endmodule

/* verif/mm_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the matrix-multiply tile
// Clock, reset, register and stream drivers,
// Z consumer with credit return, reference model,
// directed tests and cycle timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mm_tb;

  logic                      clk_i = 1'b0;
  logic                      rst_n_i;
  logic                      periph_req_i;
  logic [7:0]                periph_add_i;
  logic                      periph_wen_i;
  logic [31:0]               periph_wdata_i;
  logic                      periph_gnt_o;
  logic [31:0]               periph_rdata_o;
  logic                      periph_r_valid_o;
  logic                      x_valid_i;
  logic [mm_pkg::DATA_W-1:0] x_data_i;
  logic                      x_ready_o;
  logic                      w_valid_i;
  logic [mm_pkg::DATA_W-1:0] w_data_i;
  logic                      w_ready_o;
  logic                      y_valid_i;
  logic [mm_pkg::DATA_W-1:0] y_data_i;
  logic                      y_ready_o;
  logic                      z_valid_o;
  logic [mm_pkg::DATA_W-1:0] z_data_o;
  logic                      z_credit_i = 1'b0;
  logic                      busy_o;
  logic                      evt_o;

  // Operand matrices of the current job
  logic signed [15:0] xm [4][16];
  logic signed [15:0] wm [16][4];
  logic signed [15:0] ym [4][4];

  logic [mm_pkg::DATA_W-1:0] rx_rows [$];
  int rows_sent     = 0;
  int credits_seen  = 0;
  int credits_given = 0;
  int credit_wait   = 0;
  int evt_cnt       = 0;
  int err_mon       = 0;
  int err_test      = 0;
  int cycle_cnt     = 0;
  int hold_until    = 0;
  bit rand_delay    = 1'b0;
  int job_base      = 0;
  int job_target    = 0;

  always #4 clk_i = ~clk_i;

  mm_top u_dut (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .periph_req_i     ( periph_req_i     ),
    .periph_add_i     ( periph_add_i     ),
    .periph_wen_i     ( periph_wen_i     ),
    .periph_wdata_i   ( periph_wdata_i   ),
    .periph_gnt_o     ( periph_gnt_o     ),
    .periph_rdata_o   ( periph_rdata_o   ),
    .periph_r_valid_o ( periph_r_valid_o ),
    .x_valid_i        ( x_valid_i        ),
    .x_data_i         ( x_data_i         ),
    .x_ready_o        ( x_ready_o        ),
    .w_valid_i        ( w_valid_i        ),
    .w_data_i         ( w_data_i         ),
    .w_ready_o        ( w_ready_o        ),
    .y_valid_i        ( y_valid_i        ),
    .y_data_i         ( y_data_i         ),
    .y_ready_o        ( y_ready_o        ),
    .z_valid_o        ( z_valid_o        ),
    .z_data_o         ( z_data_o         ),
    .z_credit_i       ( z_credit_i       ),
    .busy_o           ( busy_o           ),
    .evt_o            ( evt_o            )
  );

  // Consumer side sampled mid-cycle where outputs are settled
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (z_valid_o) begin
        rx_rows.push_back(z_data_o);
        rows_sent = rows_sent + 1;
        assert (rows_sent <= int'(mm_pkg::Z_CREDITS) + credits_seen) else begin
          $display("ERROR at %0t: z_valid_o raised with no credit left", $time);
          err_mon = err_mon + 1;
        end
      end
      if (z_credit_i) begin
        credits_seen = credits_seen + 1;
      end
      if (evt_o) begin
        evt_cnt = evt_cnt + 1;
        assert (!busy_o) else begin
          $display("ERROR at %0t: busy_o still high during evt_o", $time);
          err_mon = err_mon + 1;
        end
      end
    end
  end

  // One credit back per row taken after an optional short random pause
  always @(posedge clk_i) begin
    z_credit_i <= 1'b0;
    if (rst_n_i && cycle_cnt >= hold_until && rows_sent > credits_given) begin
      if (credit_wait > 0) begin
        credit_wait = credit_wait - 1;
      end else begin
        z_credit_i    <= 1'b1;
        credits_given = credits_given + 1;
        credit_wait   = rand_delay ? int'($urandom_range(3, 0)) : 0;
      end
    end
  end

  // Five jobs of at most 16 steps take a few hundred cycles
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= 20000) begin
      $display("ERROR: timeout, the run did not finish within %0d cycles", cycle_cnt);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    assert (got == exp) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      err_test = err_test + 1;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("ERROR at %0t: %s", $time, what);
      err_test = err_test + 1;
    end
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, output logic gnt);
    @(posedge clk_i);
    periph_req_i   <= 1'b1;
    periph_add_i   <= addr;
    periph_wen_i   <= 1'b0;
    periph_wdata_i <= data;
    @(negedge clk_i);
    gnt = periph_gnt_o;
    @(posedge clk_i);
    periph_req_i <= 1'b0;
    periph_wen_i <= 1'b1;
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk_i);
    periph_req_i <= 1'b1;
    periph_add_i <= addr;
    periph_wen_i <= 1'b1;
    @(negedge clk_i);
    check_true(periph_gnt_o, "register read was not granted");
    @(posedge clk_i);
    periph_req_i <= 1'b0;
    @(negedge clk_i);
    check_true(periph_r_valid_o, "read data valid missing one cycle after the read");
    data = periph_rdata_o;
  endtask

  // Stream select 0 is X, 1 is W, anything else Y
  task automatic push_word(input int sel, input logic [mm_pkg::DATA_W-1:0] data);
    logic taken;
    taken = 1'b0;
    @(posedge clk_i);
    case (sel)
      0: begin
        x_valid_i <= 1'b1;
        x_data_i  <= data;
      end
      1: begin
        w_valid_i <= 1'b1;
        w_data_i  <= data;
      end
      default: begin
        y_valid_i <= 1'b1;
        y_data_i  <= data;
      end
    endcase
    while (!taken) begin
      @(negedge clk_i);
      case (sel)
        0:       taken = x_ready_o;
        1:       taken = w_ready_o;
        default: taken = y_ready_o;
      endcase
    end
    // Transfer happens on this edge
    @(posedge clk_i);
    case (sel)
      0:       x_valid_i <= 1'b0;
      1:       w_valid_i <= 1'b0;
      default: y_valid_i <= 1'b0;
    endcase
  endtask

  task automatic feed_bias();
    mm_pkg::mm_word_u wd;
    for (int r = 0; r < mm_pkg::MM_WIDTH; r++) begin
      for (int c = 0; c < mm_pkg::MM_HEIGHT; c++) begin
        wd.lane[c] = ym[r][c];
      end
      push_word(2, wd.raw);
    end
  endtask

  // X column and W row of each inner step from first up to last - 1
  task automatic feed_steps(input int first, input int last);
    mm_pkg::mm_word_u wd;
    for (int i = first; i < last; i++) begin
      for (int r = 0; r < mm_pkg::MM_WIDTH; r++) begin
        wd.lane[r] = xm[r][i];
      end
      push_word(0, wd.raw);
      for (int c = 0; c < mm_pkg::MM_HEIGHT; c++) begin
        wd.lane[c] = wm[i][c];
      end
      push_word(1, wd.raw);
    end
  endtask

  task automatic fill_random(input int k, input bit big);
    for (int r = 0; r < mm_pkg::MM_WIDTH; r++) begin
      for (int i = 0; i < k; i++) begin
        xm[r][i] = big ? (16'h7f00 | 16'($urandom_range(255, 0))) : 16'($urandom);
      end
      for (int c = 0; c < mm_pkg::MM_HEIGHT; c++) begin
        ym[r][c] = 16'($urandom);
      end
    end
    for (int i = 0; i < k; i++) begin
      for (int c = 0; c < mm_pkg::MM_HEIGHT; c++) begin
        wm[i][c] = big ? (16'h8000 | 16'($urandom_range(255, 0))) : 16'($urandom);
      end
    end
  endtask

  // Z row r is Y plus the X row times W wrapped to 16 bits per element
  function automatic logic [63:0] expect_row(input int r, input int k);
    mm_pkg::mm_word_u e;
    int acc;
    for (int c = 0; c < mm_pkg::MM_HEIGHT; c++) begin
      acc = int'(ym[r][c]);
      for (int i = 0; i < k; i++) begin
        acc = acc + int'(xm[r][i]) * int'(wm[i][c]);
      end
      e.lane[c] = acc[15:0];
    end
    return e.raw;
  endfunction

  task automatic launch(input int k);
    logic gnt;
    job_base   = rx_rows.size();
    job_target = evt_cnt + 1;
    reg_write(mm_pkg::REG_K_OFFS, 32'(k), gnt);
    check_true(gnt, "K write not granted while idle");
    reg_write(mm_pkg::REG_TRIGGER_OFFS, 32'h0, gnt);
    check_true(gnt, "trigger write not granted while idle");
  endtask

  task automatic check_job(input int k);
    while (evt_cnt < job_target) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    check_true(!busy_o, "busy_o still high after evt_o");
    @(posedge clk_i);
    check_true(evt_cnt == job_target, "evt_o did not pulse exactly once for the job");
    check_true(rx_rows.size() == job_base + 4, "wrong number of Z rows for the job");
    for (int r = 0; r < mm_pkg::MM_WIDTH; r++) begin
      if (job_base + r < rx_rows.size()) begin
        check_eq(rx_rows[job_base + r], expect_row(r, k), $sformatf("Z row %0d", r));
      end
    end
  endtask

  task automatic test_registers();
    logic [31:0] rd;
    logic        gnt;
    reg_write(mm_pkg::REG_K_OFFS, 32'd3, gnt);
    check_true(gnt, "K write not granted while idle");
    reg_read(mm_pkg::REG_K_OFFS, rd);
    check_eq(64'(rd), 64'd3, "K readback");
    reg_read(mm_pkg::REG_STATUS_OFFS, rd);
    check_eq(64'(rd), 64'd0, "status while idle");
    fill_random(3, 1'b0);
    launch(3);
    // Job waits in the bias phase as no Y has been pushed yet
    reg_read(mm_pkg::REG_STATUS_OFFS, rd);
    check_eq(64'(rd), 64'd1, "status while busy");
    reg_write(mm_pkg::REG_K_OFFS, 32'd9, gnt);
    check_true(!gnt, "register write was granted while busy");
    reg_read(mm_pkg::REG_K_OFFS, rd);
    check_eq(64'(rd), 64'd3, "K after refused write");
    feed_bias();
    feed_steps(0, 3);
    check_job(3);
  endtask

  task automatic test_identity();
    mm_pkg::mm_word_u e;
    fill_random(4, 1'b0);
    for (int i = 0; i < 4; i++) begin
      for (int c = 0; c < mm_pkg::MM_HEIGHT; c++) begin
        wm[i][c] = (i == c) ? 16'sd1 : 16'sd0;
        ym[i][c] = 16'sd0;
      end
    end
    launch(4);
    feed_bias();
    feed_steps(0, 4);
    check_job(4);
    for (int r = 0; r < mm_pkg::MM_WIDTH; r++) begin
      for (int c = 0; c < mm_pkg::MM_HEIGHT; c++) begin
        e.lane[c] = xm[r][c];
      end
      if (job_base + r < rx_rows.size()) begin
        check_eq(rx_rows[job_base + r], e.raw, $sformatf("identity Z row %0d", r));
      end
    end
  endtask

  task automatic test_random_tile();
    rand_delay = 1'b0;
    fill_random(7, 1'b0);
    launch(7);
    feed_bias();
    feed_steps(0, 7);
    check_job(7);
  endtask

  task automatic test_backpressure();
    fill_random(5, 1'b0);
    // Credits stay with the consumer until the operands are in
    hold_until = cycle_cnt + 100000;
    launch(5);
    feed_bias();
    feed_steps(0, 5);
    hold_until = cycle_cnt + 30;
    check_job(5);
  endtask

  task automatic test_queued_wrap();
    rand_delay = 1'b1;
    fill_random(6, 1'b1);
    feed_bias();
    feed_steps(0, 4);
    @(negedge clk_i);
    check_true(!x_ready_o, "x_ready_o high with a full X FIFO");
    check_true(!w_ready_o, "w_ready_o high with a full W FIFO");
    check_true(!y_ready_o, "y_ready_o high with a full Y FIFO");
    launch(6);
    feed_steps(4, 6);
    check_job(6);
  endtask

  initial begin
    void'($urandom(30954));
    rst_n_i        <= 1'b0;
    periph_req_i   <= 1'b0;
    periph_add_i   <= 8'h0;
    periph_wen_i   <= 1'b1;
    periph_wdata_i <= 32'h0;
    x_valid_i      <= 1'b0;
    x_data_i       <= '0;
    w_valid_i      <= 1'b0;
    w_data_i       <= '0;
    y_valid_i      <= 1'b0;
    y_data_i       <= '0;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    test_registers();
    test_identity();
    test_random_tile();
    test_backpressure();
    test_queued_wrap();

    $display("errors: %0d in tests, %0d in monitor, %0d total",
             err_test, err_mon, err_test + err_mon);
    if (err_test + err_mon == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* flist.f */
common/mm_pkg.sv
ctrl/mm_regfile.sv
logic/mm_stream_fifo.sv
engine/mm_engine.sv
logic/mm_scheduler.sv
logic/mm_z_drain.sv
logic/mm_top.sv
verif/mm_tb.sv

/* run.sh */
#!/bin/sh
# Build the matrix tile testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module mm_tb -o mm_sim > build.log 2>&1 \
  && ./obj_dir/mm_sim > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "^test passed$" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL, see sim.log"; exit 1; }
